// File: systolic_mm_pkg.sv
// shared word widths and link type; ACC_W holds sums of up to 256 full-scale signed products
`default_nettype none

package systolic_mm_pkg;

    //////////////////////////////////////////////////
    // word widths
    //////////////////////////////////////////////////

    localparam int DATA_W = 16;              // operand word
    localparam int PROD_W = 2 * DATA_W;      // full signed product
    localparam int ACC_W  = PROD_W + 8;      // 8 guard bits cover K up to 256

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // one step of a product as it moves east or south through the grid
    typedef struct packed {
        logic  valid;   // real step
        logic  first;   // load the product, drop the old sum
        logic  last;    // final step, copy sum to result
        data_t data;
    } pe_link_t;

endpackage

`default_nettype wire

// File: mm_operand_skew.sv
// row i and column j leave i+1 and j+1 cycles after the step; flags are only valid with in_valid
`timescale 1ns/1ps
`default_nettype none

module mm_operand_skew #(
    parameter int N     = 4,
    parameter int MAX_K = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic                                in_first,
    input  logic                                in_last,
    input  systolic_mm_pkg::data_t   [N-1:0]    a_col,
    input  systolic_mm_pkg::data_t   [N-1:0]    b_row,
    output systolic_mm_pkg::pe_link_t [N-1:0]   west_link,
    output systolic_mm_pkg::pe_link_t [N-1:0]   north_link
);

    localparam int CNT_W = $clog2(MAX_K + 1) + 1;   // room for saturation above MAX_K
    localparam int GAP_W = $clog2(2 * N);

    //////////////////////////////////////////////////
    // triangular delay chains
    //////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_lane
        systolic_mm_pkg::pe_link_t a_pipe [i+1];   // row i of A, i+1 stages
        systolic_mm_pkg::pe_link_t b_pipe [i+1];   // column i of B

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int s = 0; s <= i; s++) begin
                    a_pipe[s] <= '0;
                    b_pipe[s] <= '0;
                end
            end else begin
                a_pipe[0] <= '{valid: in_valid, first: in_valid & in_first,
                               last: in_valid & in_last, data: a_col[i]};
                b_pipe[0] <= '{valid: in_valid, first: in_valid & in_first,
                               last: in_valid & in_last, data: b_row[i]};
                for (int s = 1; s <= i; s++) begin
                    a_pipe[s] <= a_pipe[s-1];
                    b_pipe[s] <= b_pipe[s-1];
                end
            end
        end

        assign west_link[i]  = a_pipe[i];
        assign north_link[i] = b_pipe[i];
    end

    //////////////////////////////////////////////////
    // product length and spacing checks
    //////////////////////////////////////////////////

    logic [CNT_W-1:0] step_cnt;    // steps since the last first
    logic [CNT_W-1:0] steps_now;   // including the current step
    logic [GAP_W-1:0] gap_cnt;     // cycles since the previous last, saturating
    logic             seen_last;

    assign steps_now = in_first ? CNT_W'(1) : step_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt  <= '0;
            gap_cnt   <= '0;
            seen_last <= 1'b0;
        end else begin
            if (in_valid && steps_now <= CNT_W'(MAX_K + 1)) step_cnt <= steps_now;
            if (in_valid && in_last) begin
                gap_cnt   <= GAP_W'(1);
                seen_last <= 1'b1;
            end else if (gap_cnt != GAP_W'(2 * N - 1)) begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    a_flags_need_valid : assert property (@(posedge clk) disable iff (rst)
        (in_first || in_last) |-> in_valid)
        else $error("in_first or in_last without in_valid");

    a_k_in_range : assert property (@(posedge clk) disable iff (rst)
        in_valid |-> steps_now <= CNT_W'(MAX_K))
        else $error("product longer than MAX_K steps");

    // row 0 of a product is drained 2N-1 cycles after its last step
    a_last_spacing : assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_last && seen_last) |-> gap_cnt >= GAP_W'(2 * N - 1))
        else $error("last steps closer than 2N-1 cycles, results would be overwritten");

endmodule

`default_nettype wire

// File: mm_pe.sv
// signed MAC element; west and north must carry the same flags, the sum restarts on first
`timescale 1ns/1ps
`default_nettype none

module mm_pe (
    input  logic                        clk,
    input  logic                        rst,
    input  systolic_mm_pkg::pe_link_t   west,
    input  systolic_mm_pkg::pe_link_t   north,
    output systolic_mm_pkg::pe_link_t   east,
    output systolic_mm_pkg::pe_link_t   south,
    output systolic_mm_pkg::acc_t       res,
    output logic                        done
);

    localparam int EXT_W = systolic_mm_pkg::ACC_W - systolic_mm_pkg::PROD_W;

    systolic_mm_pkg::prod_t prod;
    systolic_mm_pkg::acc_t  prod_ext;
    systolic_mm_pkg::acc_t  acc;
    systolic_mm_pkg::acc_t  acc_next;

    //////////////////////////////////////////////////
    // multiply and accumulate
    //////////////////////////////////////////////////

    assign prod     = west.data * north.data;                   // both signed
    assign prod_ext = {{EXT_W{prod[systolic_mm_pkg::PROD_W-1]}}, prod};

    // a first step drops whatever the previous product left behind
    assign acc_next = west.first ? prod_ext : acc + prod_ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc  <= '0;
            res  <= '0;
            done <= 1'b0;
        end else begin
            done <= west.valid & west.last;        // one-cycle pulse with res
            if (west.valid) begin
                acc <= acc_next;
                if (west.last) begin
                    res <= acc_next;               // held until the next last
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // forwarding to the neighbours
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            east  <= '0;
            south <= '0;
        end else begin
            east  <= west;
            south <= north;
        end
    end

    // both operands of a step meet here after the same skew, so their flags must match
    a_flags_agree : assert property (@(posedge clk) disable iff (rst)
        west.valid |-> (north.valid && north.first == west.first
                        && north.last == west.last))
        else $error("west and north flags out of step");

endmodule

`default_nettype wire

// File: mm_result_drain.sv
// reads row r of the grid r cycles after the corner finishes; needs N >= 2 and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module mm_result_drain #(
    parameter int N = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        corner_done,
    input  systolic_mm_pkg::acc_t [N-1:0][N-1:0]        res_grid,
    output logic                                        out_valid,
    output logic [$clog2(N)-1:0]                        out_index,
    output systolic_mm_pkg::acc_t [N-1:0]               out_row
);

    localparam int IDX_W = $clog2(N);

    logic             running;    // rows 1..N-1 still to go
    logic [IDX_W-1:0] row_cnt;    // zero whenever idle
    logic             take_row;

    //////////////////////////////////////////////////
    // row sequencing
    //////////////////////////////////////////////////

    // a drain starts with row 0 in the corner_done cycle itself
    assign take_row = running | corner_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            row_cnt   <= '0;
            out_valid <= 1'b0;
            out_index <= '0;
        end else begin
            out_valid <= take_row;
            if (take_row) begin
                out_index <= row_cnt;
                if (row_cnt == IDX_W'(N - 1)) begin
                    running <= 1'b0;   // last row out
                    row_cnt <= '0;
                end else begin
                    running <= 1'b1;
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // row register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take_row) begin
            out_row <= res_grid[row_cnt];
        end
    end

    // a new corner result during a drain means a product shorter than N steps
    a_no_overlap : assert property (@(posedge clk) disable iff (rst)
        corner_done |-> !running)
        else $error("corner done while draining, K < N");

endmodule

`default_nettype wire

// File: systolic_mm_top.sv
// N >= 2, N <= K <= MAX_K <= 256, last steps of successive products >= 2N-1 cycles apart
`timescale 1ns/1ps
`default_nettype none

module systolic_mm_top #(
    parameter int N     = 4,
    parameter int MAX_K = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic                                in_first,
    input  logic                                in_last,
    input  systolic_mm_pkg::data_t [N-1:0]      a_col,
    input  systolic_mm_pkg::data_t [N-1:0]      b_row,
    output logic                                out_valid,
    output logic [$clog2(N)-1:0]                out_index,
    output systolic_mm_pkg::acc_t  [N-1:0]      out_row
);

    if (N < 2 || MAX_K < N || MAX_K > 256) begin : g_bad_params
        $error("need N >= 2 and N <= MAX_K <= 256");
    end

    systolic_mm_pkg::pe_link_t [N-1:0]          west_link;
    systolic_mm_pkg::pe_link_t [N-1:0]          north_link;
    systolic_mm_pkg::pe_link_t                  h_link [N][N+1];   // into element (i,j) from west
    systolic_mm_pkg::pe_link_t                  v_link [N+1][N];   // into element (i,j) from north
    systolic_mm_pkg::acc_t     [N-1:0][N-1:0]   res_grid;
    logic                      [N-1:0][N-1:0]   done_grid;         // only the corner is read

    //////////////////////////////////////////////////
    // operand skew
    //////////////////////////////////////////////////

    mm_operand_skew #(
        .N     (N),
        .MAX_K (MAX_K)
    ) u_skew (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_first   (in_first),
        .in_last    (in_last),
        .a_col      (a_col),
        .b_row      (b_row),
        .west_link  (west_link),
        .north_link (north_link)
    );

    for (genvar e = 0; e < N; e++) begin : g_edge
        assign h_link[e][0] = west_link[e];
        assign v_link[0][e] = north_link[e];
    end

    //////////////////////////////////////////////////
    // element grid
    //////////////////////////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            mm_pe u_pe (
                .clk   (clk),
                .rst   (rst),
                .west  (h_link[i][j]),
                .north (v_link[i][j]),
                .east  (h_link[i][j+1]),    // column N falls off the grid
                .south (v_link[i+1][j]),
                .res   (res_grid[i][j]),
                .done  (done_grid[i][j])
            );
        end
    end

    //////////////////////////////////////////////////
    // result drain
    //////////////////////////////////////////////////

    mm_result_drain #(
        .N (N)
    ) u_drain (
        .clk         (clk),
        .rst         (rst),
        .corner_done (done_grid[N-1][N-1]),  // last element to finish
        .res_grid    (res_grid),
        .out_valid   (out_valid),
        .out_index   (out_index),
        .out_row     (out_row)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// free-running clock from time 0; reset is high at start and drops after RESET_CYCLES rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;    // released on an edge, like the stimulus
    end

endmodule

`default_nettype wire

// File: tb_systolic_mm.sv
// directed tests for systolic_mm_top at N=4, MAX_K=64; expected C comes from a software matrix product
`timescale 1ns/1ps
`default_nettype none

module tb_systolic_mm;

    localparam int N      = 4;
    localparam int MAX_K  = 64;
    localparam int IDX_W  = $clog2(N);
    localparam int CLK_NS = 40;

    // watchdog budget: all steps, 3N cycles per product, idle margin
    localparam int TOTAL_STEPS = 4 + 4 + MAX_K + 8 + 7 + 4 + 4;
    localparam int PRODUCTS    = 7;
    localparam int MARGIN      = 150;
    localparam int WATCHDOG_NS = (TOTAL_STEPS + PRODUCTS * 3 * N + MARGIN) * CLK_NS;

    localparam systolic_mm_pkg::data_t MOST_NEG = 16'sh8000;
    localparam systolic_mm_pkg::data_t MOST_POS = 16'sh7FFF;

    typedef systolic_mm_pkg::acc_t [N-1:0] row_t;

    logic                           clk;
    logic                           por_rst;
    logic                           test_rst;
    logic                           rst;
    logic                           in_valid;
    logic                           in_first;
    logic                           in_last;
    systolic_mm_pkg::data_t [N-1:0] a_col;
    systolic_mm_pkg::data_t [N-1:0] b_row;
    logic                           out_valid;
    logic [IDX_W-1:0]               out_index;
    row_t                           out_row;

    systolic_mm_pkg::data_t a_m [N][MAX_K];   // A, N x K
    systolic_mm_pkg::data_t b_m [MAX_K][N];   // B, K x N
    longint                 exp_c [2][N][N];  // two slots for back-to-back products

    row_t        row_q [$];
    int          idx_q [$];
    int          cyc_q [$];
    int          last_q [$];   // edge numbers that sampled a last step
    int          cyc = 0;
    int          value_errs = 0;
    int          proto_errs = 0;
    int unsigned lcg_state = 93;

    assign rst = por_rst | test_rst;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) clk_gen (.clk(clk), .rst(por_rst));

    systolic_mm_top #(.N(N), .MAX_K(MAX_K)) dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_last   (in_last),
        .a_col     (a_col),
        .b_row     (b_row),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_row   (out_row)
    );

    //////////////////////////////////////////////////
    // monitor, sees pre-edge values only
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (in_valid && in_last && !rst) last_q.push_back(cyc);
        if (out_valid) begin
            row_q.push_back(out_row);
            idx_q.push_back(int'(out_index));
            cyc_q.push_back(cyc);
        end
    end

    //////////////////////////////////////////////////
    // stimulus and reference helpers
    //////////////////////////////////////////////////

    function automatic systolic_mm_pkg::data_t rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return systolic_mm_pkg::data_t'(lcg_state[30:15]);   // upper bits, better spread
    endfunction

    task automatic fill_random(int k);
        for (int s = 0; s < k; s++) begin
            for (int i = 0; i < N; i++) begin
                a_m[i][s] = rand_word();
                b_m[s][i] = rand_word();
            end
        end
    endtask

    task automatic compute_reference(int k, int slot);
        longint sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int s = 0; s < k; s++) sum += longint'(a_m[i][s]) * longint'(b_m[s][j]);
                exp_c[slot][i][j] = sum;
            end
        end
    endtask

    // steps 0..count-1 of a k-step product, one per cycle
    task automatic stream_steps(int k, int count);
        for (int s = 0; s < count; s++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_first <= (s == 0);
            in_last  <= (s == k - 1);
            for (int i = 0; i < N; i++) begin
                a_col[i] <= a_m[i][s];   // column s of A
                b_row[i] <= b_m[s][i];   // row s of B
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        in_first <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic wait_rows(int count, int limit, output bit ok);
        int waited;
        waited = 0;
        while (row_q.size() < count && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        ok = (row_q.size() >= count);
        assert (ok) else begin
            $display("missing result rows: %0d of %0d arrived within %0d cycles",
                     row_q.size(), count, limit);
            proto_errs++;
        end
    endtask

    task automatic check_product(int slot);
        row_t                  got_row;
        systolic_mm_pkg::acc_t want;
        int                    idx;
        int                    at;
        int                    start;
        int                    last_at;
        start   = 0;
        last_at = -1;
        if (last_q.size() > 0) last_at = last_q.pop_front();
        for (int r = 0; r < N; r++) begin
            got_row = row_q.pop_front();
            idx     = idx_q.pop_front();
            at      = cyc_q.pop_front();
            if (r == 0) start = at;
            assert (idx == r) else begin
                $display("rows out of order: expected out_index %0d, got %0d", r, idx);
                proto_errs++;
            end
            assert (at == start + r) else begin
                $display("out_valid dropped inside the row window at row %0d", r);
                proto_errs++;
            end
            for (int j = 0; j < N; j++) begin
                want = systolic_mm_pkg::acc_t'(exp_c[slot][r][j]);
                assert (got_row[j] == want) else begin
                    $display("FAIL %0t ns out_row[%0d] row %0d: expected %0d, got %0d",
                             $time, j, r, want, got_row[j]);
                    value_errs++;
                end
            end
        end
        // out_valid is set 2N edges after the edge taking the last step
        assert (last_at >= 0 && start == last_at + 2 * N + 1) else begin
            $display("first row seen at edge %0d, last step taken at edge %0d, expected gap %0d",
                     start, last_at, 2 * N + 1);
            proto_errs++;
        end
    endtask

    task automatic check_no_rows(int cycles);
        repeat (cycles) @(negedge clk);
        assert (row_q.size() == 0) else begin
            $display("%0d unexpected result rows appeared", row_q.size());
            proto_errs++;
            row_q.delete();
            idx_q.delete();
            cyc_q.delete();
        end
    endtask

    // streams the current A and B and checks C against slot 0
    task automatic product_and_check(int k);
        bit ok;
        stream_steps(k, k);
        go_idle();
        wait_rows(N, 4 * N + 4, ok);
        if (ok) check_product(0);
        check_no_rows(3);   // out_valid lasted N cycles only
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic test_identity();
        fill_random(N);
        for (int i = 0; i < N; i++) begin
            for (int s = 0; s < N; s++) a_m[i][s] = (i == s) ? 16'sd1 : 16'sd0;
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) exp_c[0][i][j] = longint'(b_m[i][j]);   // I times B
        end
        product_and_check(N);
    endtask

    task automatic test_random();
        fill_random(N);
        compute_reference(N, 0);
        product_and_check(N);
    endtask

    task automatic test_extremes();
        for (int s = 0; s < MAX_K; s++) begin
            for (int i = 0; i < N; i++) begin
                a_m[i][s] = (i % 2 == 0) ? MOST_NEG : MOST_POS;
                b_m[s][i] = (i % 2 == 0 || s % 2 == 0) ? MOST_NEG : MOST_POS;
            end
        end
        compute_reference(MAX_K, 0);   // peak 64 * 2^30, well inside 40 bits
        product_and_check(MAX_K);
    endtask

    task automatic test_back_to_back();
        bit ok;
        fill_random(8);
        compute_reference(8, 0);
        stream_steps(8, 8);
        fill_random(7);                // last steps 7 cycles apart, no idle cycle
        compute_reference(7, 1);
        stream_steps(7, 7);
        go_idle();
        wait_rows(2 * N, 7 + 4 * N + 4, ok);
        if (ok) begin
            check_product(0);
            check_product(1);
        end
        check_no_rows(3);
    endtask

    task automatic test_reset_mid_product();
        fill_random(N);
        stream_steps(N, N);            // whole product, still inside the grid at reset
        go_idle();
        test_rst <= 1'b1;
        repeat (2) @(posedge clk);
        test_rst <= 1'b0;
        last_q.delete();               // the aborted product never drains
        check_no_rows(4 * N);
        fill_random(N);
        compute_reference(N, 0);
        product_and_check(N);
    endtask

    //////////////////////////////////////////////////
    // sequencing and watchdog
    //////////////////////////////////////////////////

    initial begin
        in_valid <= 1'b0;
        in_first <= 1'b0;
        in_last  <= 1'b0;
        a_col    <= '0;
        b_row    <= '0;
        test_rst <= 1'b0;
        wait (por_rst === 1'b0);
        @(posedge clk);
        $display("test 1: identity times random, K=N");
        test_identity();
        $display("test 2: random signed, K=N");
        test_random();
        $display("test 3: signed extremes, K=MAX_K");
        test_extremes();
        $display("test 4: back-to-back products");
        test_back_to_back();
        $display("test 5: reset in the middle of a product");
        test_reset_mid_product();
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: systolic_mm.f
systolic_mm_pkg.sv
mm_operand_skew.sv
mm_pe.sv
mm_result_drain.sv
systolic_mm_top.sv
tb_clock_gen.sv
tb_systolic_mm.sv

// File: Makefile
# build and run the testbench with Verilator; the log decides pass or fail

sim:
	verilator --binary --timing --assert -Wno-fatal -f systolic_mm.f --top-module tb_systolic_mm -o vsim
	./obj_dir/vsim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
